//--- chess_config.svh
// ########################################
// board geometry and command opcodes
// opcodes sit in address bits 7..4
// dropped opcodes decode as no-ops
// ########################################
`ifndef CHESS_CONFIG_SVH
`define CHESS_CONFIG_SVH

`define CHESS_FILES    8
`define CHESS_RANKS    8
`define CHESS_SQUARES  64

// command opcodes
`define OPC_FIND_SRC   4'b1111
`define OPC_FIND_DST   4'b1110
`define OPC_SET_ENABLE 4'b1101
`define OPC_ENABLE_ALL 4'b1100
`define OPC_SET_SQUARE 4'b1011
`define OPC_GET_SQUARE 4'b0101

`endif

//--- chess_pkg.sv
// ########################################
// shared types for the move finder
// square code is {colour, piece}, colour 1 = them
// ########################################
package chess_pkg;

    typedef enum logic [2:0] {
        PAWN   = 3'd0,
        KNIGHT = 3'd1,
        BISHOP = 3'd2,
        ROOK   = 3'd3,
        QUEEN  = 3'd4,
        KING   = 3'd5,
        EMPTY  = 3'd7
    } piece_e;

    typedef struct packed {
        logic   colour;
        piece_e piece;
    } square_t;

    typedef logic [5:0] sq_idx_t;
    typedef logic [2:0] prio_t;

    typedef enum logic {
        MODE_VICTIM    = 1'b0,
        MODE_AGGRESSOR = 1'b1
    } find_mode_e;

    // per-file vectors handed from one rank to the next
    typedef struct packed {
        logic [7:0] north;
        logic [7:0] northeast;
        logic [7:0] northwest;
        logic [7:0] knight_near;  // knight targets one rank up
        logic [7:0] knight_far;   // raw knight sources of this rank
        logic [7:0] king;
        logic [7:0] pawn;
        logic [7:0] knight_prev;  // raw knight sources two ranks down
    } ray_t;

    typedef struct packed {
        logic       active;
        find_mode_e mode;
        sq_idx_t    xmit;
    } find_cmd_t;

    // data_out layout
    typedef struct packed {
        logic    illegal;
        logic    none;
        sq_idx_t square;
    } move_result_t;

endpackage

//--- board_regs.sv
// ########################################
// one command per clock, no handshake
// square number is {addr[1:0], data_in[7:4]}
// board and mask feed the network directly
// ########################################
`timescale 1ns/1ps
`include "chess_config.svh"

module board_regs (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [7:0]                               addr,
    input  logic [7:0]                               data_in,
    output chess_pkg::square_t [`CHESS_SQUARES-1:0] board,
    output logic [`CHESS_SQUARES-1:0]               enable_mask,
    output chess_pkg::find_cmd_t                     find_q,
    output logic                                     rd_valid,
    output chess_pkg::square_t                       rd_data
);
    import chess_pkg::*;

    logic [3:0] opcode;
    sq_idx_t    sq;
    logic       is_find;

    assign opcode  = addr[7:4];
    assign sq      = {addr[1:0], data_in[7:4]};
    assign is_find = (opcode == `OPC_FIND_SRC) || (opcode == `OPC_FIND_DST);

    // piece codes and enable mask
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // every square starts as them, empty
            board       <= '1;
            enable_mask <= '1;
        end else begin
            case (opcode)
                `OPC_SET_SQUARE: begin
                    board[sq] <= square_t'(data_in[3:0]);
                end
                `OPC_SET_ENABLE: begin
                    enable_mask[sq] <= data_in[0];
                end
                `OPC_ENABLE_ALL: begin
                    enable_mask <= '1;
                end
                default: begin
                end
            endcase
        end
    end

    // find launch and read strobe, both live for one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            find_q   <= '0;
            rd_valid <= 1'b0;
        end else begin
            find_q.active <= is_find;
            find_q.mode   <= (opcode == `OPC_FIND_SRC) ? MODE_AGGRESSOR : MODE_VICTIM;
            // FIND-DST ignores the square field
            find_q.xmit   <= sq;
            rd_valid      <= (opcode == `OPC_GET_SQUARE);
        end
    end

    // read value, qualified by rd_valid
    always_ff @(posedge clk) begin
        if (opcode == `OPC_GET_SQUARE) begin
            rd_data <= board[sq];
        end
    end

endmodule

//--- square_cell.sv
// ########################################
// one square of the move network
// rays pass through empty squares only
// priority is 0 when the square is disabled
// ########################################
`timescale 1ns/1ps

module square_cell (
    input  chess_pkg::square_t    code,
    input  chess_pkg::find_mode_e mode,
    input  logic                  is_xmit,
    input  logic                  enabled,
    input  logic                  from_south,
    input  logic                  from_west,
    input  logic                  from_southeast,
    input  logic                  from_southwest,
    input  logic                  knight_hit,
    input  logic                  king_hit,
    input  logic                  pawn_push,
    input  logic                  pawn_cap,
    output logic                  to_north,
    output logic                  to_east,
    output logic                  to_northeast,
    output logic                  to_northwest,
    output logic                  knight_src,
    output logic                  king_src,
    output logic                  pawn_src,
    output chess_pkg::prio_t      prio,
    output logic                  illegal
);
    import chess_pkg::*;

    logic ours;
    logic victim;
    logic xmit_all;
    logic gen_orth;
    logic gen_diag;
    logic pass;
    logic orth_hit;
    logic diag_hit;
    logic attacked;

    assign ours     = (code.colour == 1'b0);
    assign victim   = (mode == MODE_VICTIM);
    // in aggressor mode the addressed square sends every shape
    assign xmit_all = !victim && is_xmit;

    assign gen_orth   = xmit_all || (victim && ours && (code.piece == ROOK ||
                                                         code.piece == QUEEN));
    assign gen_diag   = xmit_all || (victim && ours && (code.piece == BISHOP ||
                                                         code.piece == QUEEN));
    assign knight_src = xmit_all || (victim && ours && code.piece == KNIGHT);
    assign king_src   = xmit_all || (victim && ours && code.piece == KING);
    assign pawn_src   = xmit_all || (victim && ours && code.piece == PAWN);

    assign pass = (victim || !is_xmit) && (code.piece == EMPTY);

    assign to_north     = pass ? from_south     : gen_orth;
    assign to_east      = pass ? from_west      : gen_orth;
    assign to_northeast = pass ? from_southwest : gen_diag;
    assign to_northwest = pass ? from_southeast : gen_diag;

    assign orth_hit = from_south || from_west;
    assign diag_hit = from_southeast || from_southwest;
    assign attacked = orth_hit || diag_hit || knight_hit || king_hit || pawn_cap;

    always_comb begin
        prio    = '0;
        illegal = 1'b0;
        if (enabled) begin
            if (victim) begin
                illegal = attacked && !ours && (code.piece == KING);
                if (code.piece == EMPTY) begin
                    prio = (attacked || pawn_push) ? 3'd1 : 3'd0;
                end else if (!ours && attacked) begin
                    case (code.piece)
                        QUEEN:   prio = 3'd6;
                        ROOK:    prio = 3'd5;
                        BISHOP:  prio = 3'd4;
                        KNIGHT:  prio = 3'd3;
                        PAWN:    prio = 3'd2;
                        default: prio = 3'd0;
                    endcase
                end
            end else if (ours) begin
                // cheapest aggressor scores highest
                case (code.piece)
                    PAWN:    prio = (pawn_cap || pawn_push) ? 3'd6 : 3'd0;
                    KNIGHT:  prio = knight_hit ? 3'd5 : 3'd0;
                    BISHOP:  prio = diag_hit ? 3'd4 : 3'd0;
                    ROOK:    prio = orth_hit ? 3'd3 : 3'd0;
                    QUEEN:   prio = (orth_hit || diag_hit) ? 3'd2 : 3'd0;
                    KING:    prio = king_hit ? 3'd1 : 3'd0;
                    default: prio = 3'd0;
                endcase
            end
        end
    end

endmodule

//--- rank_stage.sv
// ########################################
// one rank of eight square cells
// file index grows to the east
// ########################################
`timescale 1ns/1ps
`include "chess_config.svh"

module rank_stage (
    input  chess_pkg::square_t [`CHESS_FILES-1:0] rank_codes,
    input  logic [`CHESS_FILES-1:0]               rank_enable,
    input  logic [2:0]                            rank_index,
    input  chess_pkg::find_cmd_t                  find,
    input  chess_pkg::ray_t                       ray_in,
    output chess_pkg::ray_t                       ray_out,
    output chess_pkg::prio_t [`CHESS_FILES-1:0]   prio_row,
    output logic [`CHESS_FILES-1:0]               illegal_row
);
    import chess_pkg::*;

    logic [`CHESS_FILES-1:0] to_east;
    logic [`CHESS_FILES-1:0] west_in;
    logic [`CHESS_FILES-1:0] se_in;
    logic [`CHESS_FILES-1:0] sw_in;
    logic [`CHESS_FILES-1:0] to_north;
    logic [`CHESS_FILES-1:0] to_ne;
    logic [`CHESS_FILES-1:0] to_nw;
    logic [`CHESS_FILES-1:0] knight_src;
    logic [`CHESS_FILES-1:0] king_src;
    logic [`CHESS_FILES-1:0] pawn_src;
    logic [`CHESS_FILES-1:0] knight_tgt;
    logic [`CHESS_FILES-1:0] king_tgt;
    logic [`CHESS_FILES-1:0] cap_tgt;

    // east chain runs across the rank
    assign west_in = to_east << 1;
    assign se_in   = ray_in.northwest >> 1;
    assign sw_in   = ray_in.northeast << 1;

    // knights one rank down arrive pre-shifted, two ranks down still need +-1
    assign knight_tgt = ray_in.knight_near | (ray_in.knight_prev << 1) |
                        (ray_in.knight_prev >> 1);
    // king from below plus same-rank neighbours
    assign king_tgt   = ray_in.king | (ray_in.king << 1) | (ray_in.king >> 1) |
                        (king_src << 1) | (king_src >> 1);
    assign cap_tgt    = (ray_in.pawn << 1) | (ray_in.pawn >> 1);

    for (genvar f = 0; f < `CHESS_FILES; f++) begin : g_file
        square_cell u_cell (
            .code           (rank_codes[f]),
            .mode           (find.mode),
            .is_xmit        (find.xmit == {rank_index, 3'(f)}),
            .enabled        (rank_enable[f]),
            .from_south     (ray_in.north[f]),
            .from_west      (west_in[f]),
            .from_southeast (se_in[f]),
            .from_southwest (sw_in[f]),
            .knight_hit     (knight_tgt[f]),
            .king_hit       (king_tgt[f]),
            .pawn_push      (ray_in.pawn[f]),
            .pawn_cap       (cap_tgt[f]),
            .to_north       (to_north[f]),
            .to_east        (to_east[f]),
            .to_northeast   (to_ne[f]),
            .to_northwest   (to_nw[f]),
            .knight_src     (knight_src[f]),
            .king_src       (king_src[f]),
            .pawn_src       (pawn_src[f]),
            .prio           (prio_row[f]),
            .illegal        (illegal_row[f])
        );
    end

    assign ray_out.north       = to_north;
    assign ray_out.northeast   = to_ne;
    assign ray_out.northwest   = to_nw;
    assign ray_out.knight_near = (knight_src << 2) | (knight_src >> 2);
    assign ray_out.knight_far  = knight_src;
    assign ray_out.king        = king_src;
    assign ray_out.pawn        = pawn_src;
    assign ray_out.knight_prev = ray_in.knight_far;

endmodule

//--- move_arbiter.sv
// ########################################
// highest priority wins, ties go to lower index
// data_out holds until the next find or read
// ########################################
`timescale 1ns/1ps
`include "chess_config.svh"

module move_arbiter (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  chess_pkg::find_cmd_t                   find_q,
    input  chess_pkg::prio_t [`CHESS_SQUARES-1:0] prio_all,
    input  logic [`CHESS_SQUARES-1:0]             illegal_all,
    input  logic                                   rd_valid,
    input  chess_pkg::square_t                     rd_data,
    output chess_pkg::move_result_t                data_out
);
    import chess_pkg::*;

    prio_t        best_prio;
    sq_idx_t      best_sq;
    move_result_t find_result;

    // index order scan, strict compare keeps the earliest maximum
    always_comb begin
        best_prio = '0;
        best_sq   = '0;
        for (int i = 0; i < `CHESS_SQUARES; i++) begin
            if (prio_all[i] > best_prio) begin
                best_prio = prio_all[i];
                best_sq   = sq_idx_t'(i);
            end
        end
    end

    // square stays 0 when nothing scored
    assign find_result.illegal = |illegal_all;
    assign find_result.none    = (best_prio == '0);
    assign find_result.square  = best_sq;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_out <= '0;
        end else if (find_q.active) begin
            data_out <= find_result;
        end else if (rd_valid) begin
            data_out <= move_result_t'({4'h0, rd_data});
        end
    end

endmodule

//--- chess_movegen_top.sv
// ########################################
// chess move finder top level
// result is valid one cycle after a find
// rays travel north, east and the two north diagonals only
// ########################################
`timescale 1ns/1ps
`include "chess_config.svh"

module chess_movegen_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              addr,
    input  logic [7:0]              data_in,
    output chess_pkg::move_result_t data_out
);
    import chess_pkg::*;

    square_t [`CHESS_SQUARES-1:0] board;
    logic [`CHESS_SQUARES-1:0]    enable_mask;
    find_cmd_t                    find_q;
    logic                         rd_valid;
    square_t                      rd_data;
    prio_t [`CHESS_SQUARES-1:0]   prio_all;
    logic [`CHESS_SQUARES-1:0]    illegal_all;

    // entry r feeds rank r, the last one leaves the board
    ray_t ray_chain [`CHESS_RANKS+1];

    board_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (addr),
        .data_in     (data_in),
        .board       (board),
        .enable_mask (enable_mask),
        .find_q      (find_q),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data)
    );

    assign ray_chain[0] = '0;

    for (genvar r = 0; r < `CHESS_RANKS; r++) begin : g_rank
        rank_stage u_stage (
            .rank_codes  (board[r*`CHESS_FILES +: `CHESS_FILES]),
            .rank_enable (enable_mask[r*`CHESS_FILES +: `CHESS_FILES]),
            .rank_index  (3'(r)),
            .find        (find_q),
            .ray_in      (ray_chain[r]),
            .ray_out     (ray_chain[r+1]),
            .prio_row    (prio_all[r*`CHESS_FILES +: `CHESS_FILES]),
            .illegal_row (illegal_all[r*`CHESS_FILES +: `CHESS_FILES])
        );
    end

    move_arbiter u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .find_q      (find_q),
        .prio_all    (prio_all),
        .illegal_all (illegal_all),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .data_out    (data_out)
    );

endmodule

//--- chess_checker.sv
// ########################################
// assertions on the arbiter result register
// bound into move_arbiter by the testbench
// ########################################
`timescale 1ns/1ps

module chess_checker (
    input logic                    clk,
    input logic                    rst_n,
    input chess_pkg::find_cmd_t    find_q,
    input logic                    rd_valid,
    input chess_pkg::move_result_t data_out
);

    int unsigned fail_count = 0;

    // reset clears the result register
    a_reset_clear: assert property (@(posedge clk) !rst_n |=> data_out == '0)
        else begin
            $error("data_out not cleared while reset is held");
            fail_count++;
        end

    a_none_square: assert property (@(posedge clk) disable iff (!rst_n)
        data_out.none |-> data_out.square == '0)
        else begin
            $error("result flags none but square is not 0");
            fail_count++;
        end

    // only a find or a read may load a new value
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(data_out) |-> ($past(find_q.active) || $past(rd_valid)))
        else begin
            $error("data_out changed without a find or read");
            fail_count++;
        end

endmodule

//--- chess_tb_clkgen.sv
// ########################################
// testbench clock and synchronous reset
// 4 ns period, reset low for 8 rising edges
// ########################################
`timescale 1ns/1ps

module chess_tb_clkgen #(
    parameter real period_ns    = 4.0,
    parameter int  reset_cycles = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    // released on a rising edge, like every other driven input
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- chess_tb.sv
// ########################################
// testbench for the chess move finder
// one table row is driven per clock
// a row's result is checked two edges later
// ########################################
`timescale 1ns/1ps
`include "chess_config.svh"

module chess_tb;
    import chess_pkg::*;

    typedef struct packed {
        logic [3:0] opc;
        logic [5:0] sq;
        logic [3:0] data;
        logic       check;
        logic [7:0] want;
        logic [2:0] grp;
    } row_t;

    logic         clk;
    logic         rst_n;
    logic [7:0]   addr;
    logic [7:0]   data_in;
    move_result_t data_out;

    row_t   rows[$];
    logic [3:0] model [64];
    integer seed;
    int     n_checks;
    int     n_errors;
    int     grp_checks [8];
    int     grp_errors [8];
    int     cur_grp;
    int     cycle_limit;
    int     cycle_count;
    string  test_name [8] = '{"", "reset contents", "random set/get", "victim rook lines",
                              "aggressor choice", "enable mask", "tie and back-to-back", ""};

    chess_tb_clkgen i_clkgen (.clk(clk), .rst_n(rst_n));

    chess_movegen_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (data_out)
    );

    bind move_arbiter chess_checker u_chk (
        .clk      (clk),
        .rst_n    (rst_n),
        .find_q   (find_q),
        .rd_valid (rd_valid),
        .data_out (data_out)
    );

    task automatic add_row(input logic [3:0] opc, input logic [5:0] sq, input logic [3:0] data,
                           input logic check, input logic [7:0] want, input logic [2:0] grp);
        rows.push_back({opc, sq, data, check, want, grp});
    endtask

    task automatic add_find(input logic [3:0] opc, input logic [5:0] sq,
                            input logic [7:0] want, input logic [2:0] grp);
        add_row(opc, sq, 4'h0, 1'b1, want, grp);
    endtask

    // board model follows every square write
    task automatic put_piece(input logic [5:0] sq, input logic [3:0] code, input logic [2:0] grp);
        model[sq] = code;
        add_row(`OPC_SET_SQUARE, sq, code, 1'b0, 8'h00, grp);
    endtask

    task automatic get_piece(input logic [5:0] sq, input logic [2:0] grp);
        add_row(`OPC_GET_SQUARE, sq, 4'h0, 1'b1, {4'h0, model[sq]}, grp);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [5:0]  sq_a;
        logic [5:0]  sq_b;
        add_row(`OPC_GET_SQUARE, 6'd0, 4'h0, 1'b1, 8'h0F, 3'd1);
        add_row(`OPC_GET_SQUARE, 6'd27, 4'h0, 1'b1, 8'h0F, 3'd1);
        add_row(`OPC_GET_SQUARE, 6'd63, 4'h0, 1'b1, 8'h0F, 3'd1);
        // our rook in the corner, their pawn up the file, their queen along the rank
        put_piece(6'd0, 4'h3, 3'd3);
        put_piece(6'd24, 4'h8, 3'd3);
        put_piece(6'd5, 4'hC, 3'd3);
        add_find(`OPC_FIND_DST, 6'd0, 8'h05, 3'd3);
        // our pawn blocks the rank, the pawn on the file is left
        put_piece(6'd2, 4'h0, 3'd3);
        add_find(`OPC_FIND_DST, 6'd0, 8'h18, 3'd3);
        // open file up to their king, best left is the empty square 1
        put_piece(6'd24, 4'hF, 3'd3);
        put_piece(6'd40, 4'hD, 3'd3);
        add_find(`OPC_FIND_DST, 6'd0, 8'h81, 3'd3);
        // target 4 is reached by our pawn on 13 and our rook on 28
        put_piece(6'd28, 4'h3, 3'd4);
        put_piece(6'd13, 4'h0, 3'd4);
        add_find(`OPC_FIND_SRC, 6'd4, 8'h0D, 3'd4);
        add_row(`OPC_SET_ENABLE, 6'd13, 4'h0, 1'b0, 8'h00, 3'd5);
        add_find(`OPC_FIND_SRC, 6'd4, 8'h1C, 3'd5);
        add_row(`OPC_ENABLE_ALL, 6'd0, 4'h0, 1'b0, 8'h00, 3'd5);
        add_find(`OPC_FIND_SRC, 6'd4, 8'h0D, 3'd5);
        for (int s = 0; s < `CHESS_SQUARES; s++) begin
            add_row(`OPC_SET_ENABLE, 6'(s), 4'h0, 1'b0, 8'h00, 3'd5);
        end
        add_find(`OPC_FIND_DST, 6'd0, 8'h40, 3'd5);
        add_row(`OPC_ENABLE_ALL, 6'd0, 4'h0, 1'b0, 8'h00, 3'd5);
        // their rooks on 31 and 60 both score 5, king on 40 still in check
        put_piece(6'd31, 4'hB, 3'd6);
        put_piece(6'd60, 4'hB, 3'd6);
        add_find(`OPC_FIND_DST, 6'd0, 8'h9F, 3'd6);
        add_find(`OPC_FIND_SRC, 6'd4, 8'h0D, 3'd6);
        for (int n = 0; n < 40; n++) begin
            rnd  = $random(seed);
            sq_a = rnd[5:0];
            sq_b = rnd[16] ? sq_a : rnd[29:24];
            put_piece(sq_a, rnd[11:8], 3'd2);
            get_piece(sq_b, 3'd2);
        end
    endtask

    task automatic check(input logic [7:0] actual, input logic [7:0] want, input string what);
        n_checks++;
        grp_checks[cur_grp]++;
        if (actual !== want) begin
            n_errors++;
            grp_errors[cur_grp]++;
            $display("FAIL at time %0t: %s, data_out %h, expected %h", $time, what, actual, want);
        end
    endtask

    task automatic settle_row(input int j);
        cur_grp = rows[j].grp;
        if (rows[j].check) begin
            check(data_out, rows[j].want, $sformatf("row %0d of test %0d", j, cur_grp));
        end
        // last row of a test closes it
        if (j == rows.size() - 1 || rows[j + 1].grp != rows[j].grp) begin
            $display("test %0d %s: %0d checks, %0d errors", cur_grp, test_name[cur_grp],
                     grp_checks[cur_grp], grp_errors[cur_grp]);
        end
    endtask

    initial begin
        addr     = 8'h00;
        data_in  = 8'h00;
        seed     = 32'hafb61abf;
        n_checks = 0;
        n_errors = 0;
        for (int s = 0; s < `CHESS_SQUARES; s++) begin
            model[s] = 4'hF;
        end
        build_table();
        cycle_limit = rows.size() * 3 + 40;
        wait (rst_n === 1'b1);
        for (int i = 0; i < rows.size() + 2; i++) begin
            @(posedge clk);
            if (i < rows.size()) begin
                addr    <= {rows[i].opc, 2'b00, rows[i].sq[5:4]};
                data_in <= {rows[i].sq[3:0], rows[i].data};
            end else begin
                addr    <= 8'h00;
                data_in <= 8'h00;
            end
            @(negedge clk);
            if (i >= 2) begin
                settle_row(i - 2);
            end
        end
        $display("summary: %0d checks, %0d errors, %0d assertion failures",
                 n_checks, n_errors, i_dut.u_arb.u_chk.fail_count);
        if (n_errors == 0 && i_dut.u_arb.u_chk.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        wait (cycle_limit > 0);
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: the run hung and did not finish within %0d cycles", cycle_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
chess_pkg.sv
board_regs.sv
square_cell.sv
rank_stage.sv
move_arbiter.sv
chess_movegen_top.sv
chess_checker.sv
chess_tb_clkgen.sv
chess_tb.sv
